//--- src/axis_adapter.sv
////////////////////
// AXI-Stream upsizing width adapter
// packs narrow beats into wide words behind a one-beat skid buffer
////////////////////

module axis_adapter #(
    parameter int s_data_width = stream_pack_pkg::in_data_width,
    parameter int m_data_width = stream_pack_pkg::out_data_width
) (
    input  logic clk,
    input  logic rstn,
    axis_if.snk  s,
    axis_if.src  m
);

    localparam int s_keep_width = s_data_width / 8;
    localparam int m_keep_width = m_data_width / 8;
    // narrow beats per wide word
    localparam int seg_count    = m_data_width / s_data_width;
    localparam int seg_bits     = (seg_count > 1) ? $clog2(seg_count) : 1;

    logic [seg_bits-1:0]     seg;

    // skid buffer
    logic [s_data_width-1:0] skid_data;
    logic [s_keep_width-1:0] skid_keep;
    logic                    skid_valid;
    logic                    skid_last;
    stream_pack_pkg::lane_t  skid_dest;

    // output register
    logic [m_data_width-1:0] out_data;
    logic [m_keep_width-1:0] out_keep;
    logic                    out_valid;
    logic                    out_last;
    stream_pack_pkg::lane_t  out_dest;

    logic                    out_free;
    logic                    take;
    logic                    skid_load;
    logic                    word_done;
    logic [s_data_width-1:0] cur_data;
    logic [s_keep_width-1:0] cur_keep;
    logic                    cur_last;
    stream_pack_pkg::lane_t  cur_dest;

    assign s.tready = !skid_valid;

    assign m.tdata  = out_data;
    assign m.tkeep  = out_keep;
    assign m.tvalid = out_valid;
    assign m.tlast  = out_last;
    assign m.tdest  = out_dest;

    // output register can take a segment this cycle
    assign out_free = !out_valid || m.tready;

    // buffered byte goes first, otherwise straight from the input
    assign cur_data = skid_valid ? skid_data : s.tdata;
    assign cur_keep = skid_valid ? skid_keep : s.tkeep;
    assign cur_last = skid_valid ? skid_last : s.tlast;
    assign cur_dest = skid_valid ? skid_dest : s.tdest;

    assign take      = out_free && (skid_valid || s.tvalid);
    assign skid_load = !out_free && s.tvalid && s.tready;
    assign word_done = cur_last || (seg == seg_bits'(seg_count - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seg        <= '0;
            skid_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= out_valid && !m.tready;

            if (take) begin
                skid_valid <= 1'b0;
                if (word_done) begin
                    seg       <= '0;
                    out_valid <= 1'b1;
                end else begin
                    seg <= seg + 1'b1;
                end
            end else if (skid_load) begin
                // output stalled, park one more beat
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (seg == '0) begin
                // new word starts, clear the upper bytes and keep bits
                out_data <= m_data_width'(cur_data);
                out_keep <= m_keep_width'(cur_keep);
            end else begin
                out_data[seg*s_data_width +: s_data_width] <= cur_data;
                out_keep[seg*s_keep_width +: s_keep_width] <= cur_keep;
            end
            out_last <= cur_last;
            out_dest <= cur_dest;
        end

        if (skid_load) begin
            skid_data <= s.tdata;
            skid_keep <= s.tkeep;
            skid_last <= s.tlast;
            skid_dest <= s.tdest;
        end
    end

endmodule

//--- src/axis_dispatch.sv
////////////////////
// stream dispatcher
// steers each input packet to the lane named by tdest
////////////////////

module axis_dispatch #(
    parameter int chan_count = stream_pack_pkg::chan_count,
    parameter int data_width = stream_pack_pkg::in_data_width
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [data_width-1:0]  s_tdata,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    input  logic                   s_tlast,
    input  stream_pack_pkg::lane_t s_tdest,
    axis_if.src                    lanes [chan_count]
);

    logic                   in_pkt;
    stream_pack_pkg::lane_t sel_reg;
    stream_pack_pkg::lane_t sel;
    logic [chan_count-1:0]  lane_ready;

    // first beat picks the lane from tdest, later beats follow the stored choice
    assign sel = in_pkt ? sel_reg : s_tdest;

    for (genvar i = 0; i < chan_count; i++) begin : g_lane
        assign lanes[i].tdata  = s_tdata;
        assign lanes[i].tkeep  = '1;
        assign lanes[i].tlast  = s_tlast;
        assign lanes[i].tdest  = sel;
        assign lanes[i].tvalid = s_tvalid && (sel == stream_pack_pkg::lane_t'(i));
        assign lane_ready[i]   = lanes[i].tready;
    end

    // ready comes back from the selected lane only
    always_comb begin
        s_tready = 1'b0;
        for (int i = 0; i < chan_count; i++) begin
            if (sel == stream_pack_pkg::lane_t'(i)) begin
                s_tready = lane_ready[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_pkt  <= 1'b0;
            sel_reg <= '0;
        end else if (s_tvalid && s_tready) begin
            // route is held from the first beat until tlast
            in_pkt  <= !s_tlast;
            sel_reg <= sel;
        end
    end

endmodule

//--- src/axis_if.sv
////////////////////
// AXI-Stream interface
// data, keep, last and dest with a valid/ready handshake
////////////////////

interface axis_if #(
    parameter int data_width = 8,
    parameter int keep_width = (data_width + 7) / 8
);

    logic [data_width-1:0]  tdata;
    logic [keep_width-1:0]  tkeep;
    logic                   tvalid;
    logic                   tready;
    logic                   tlast;
    stream_pack_pkg::lane_t tdest;

    // stream producer
    modport src (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tdest,
        input  tready
    );

    // stream consumer
    modport snk (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        input  tdest,
        output tready
    );

endinterface

//--- src/axis_merge.sv
////////////////////
// packet merger
// round-robin arbiter that drains whole packets from the lanes
////////////////////

module axis_merge #(
    parameter int chan_count = stream_pack_pkg::chan_count,
    parameter int data_width = stream_pack_pkg::out_data_width,
    parameter int keep_width = stream_pack_pkg::out_keep_width
) (
    input  logic                   clk,
    input  logic                   rstn,
    axis_if.snk                    lanes [chan_count],
    output logic [data_width-1:0]  m_tdata,
    output logic [keep_width-1:0]  m_tkeep,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output logic                   m_tlast,
    output stream_pack_pkg::lane_t m_tdest
);

    logic [data_width-1:0]  lane_data  [chan_count];
    logic [keep_width-1:0]  lane_keep  [chan_count];
    logic                   lane_valid [chan_count];
    logic                   lane_last  [chan_count];
    stream_pack_pkg::lane_t lane_dest  [chan_count];

    logic                   locked;
    stream_pack_pkg::lane_t grant_reg;
    stream_pack_pkg::lane_t pick;
    logic                   found;
    stream_pack_pkg::lane_t grant;

    for (genvar i = 0; i < chan_count; i++) begin : g_lane
        assign lane_data[i]   = lanes[i].tdata;
        assign lane_keep[i]   = lanes[i].tkeep;
        assign lane_valid[i]  = lanes[i].tvalid;
        assign lane_last[i]   = lanes[i].tlast;
        assign lane_dest[i]   = lanes[i].tdest;
        assign lanes[i].tready = m_tready && m_tvalid
                                 && (grant == stream_pack_pkg::lane_t'(i));
    end

    // next valid lane after the last one granted
    always_comb begin
        pick  = grant_reg;
        found = 1'b0;
        for (int k = 1; k <= chan_count; k++) begin
            if (!found && lane_valid[(int'(grant_reg) + k) % chan_count]) begin
                pick  = stream_pack_pkg::lane_t'((int'(grant_reg) + k) % chan_count);
                found = 1'b1;
            end
        end
    end

    assign grant = locked ? grant_reg : pick;

    assign m_tvalid = lane_valid[grant];
    assign m_tdata  = lane_data[grant];
    assign m_tkeep  = lane_keep[grant];
    assign m_tlast  = lane_last[grant];
    // the dispatcher tags every lane with its own index
    assign m_tdest  = lane_dest[grant];

    // lock as soon as a beat is offered so the choice cannot move under a stall
    always_ff @(posedge clk) begin
        if (!rstn) begin
            locked    <= 1'b0;
            grant_reg <= stream_pack_pkg::lane_t'(chan_count - 1);
        end else if (m_tvalid) begin
            grant_reg <= grant;
            locked    <= !(m_tready && m_tlast);
        end
    end

endmodule

//--- src/stream_pack_pkg.sv
////////////////////
// stream packer shared definitions
// bus widths, lane count and the lane index type
////////////////////

package stream_pack_pkg;

    // narrow input stream, one byte per beat
    localparam int in_data_width = 8;

    // lane and output stream width
    localparam int out_data_width = 32;

    // byte lanes on the wide side
    localparam int out_keep_width = out_data_width / 8;

    // number of adapter lanes behind the dispatcher
    localparam int chan_count = 4;

    // tdest carries the lane index
    localparam int dest_width = 2;

    typedef logic [dest_width-1:0] lane_t;

endpackage

//--- src/stream_pack_top.sv
////////////////////
// multi-channel stream packer
// dispatcher, one width adapter per lane, packet merger
////////////////////

module stream_pack_top #(
    parameter int chan_count     = stream_pack_pkg::chan_count,
    parameter int in_data_width  = stream_pack_pkg::in_data_width,
    parameter int out_data_width = stream_pack_pkg::out_data_width
) (
    input  logic                        clk,
    input  logic                        rstn,

    // narrow input stream
    input  logic [in_data_width-1:0]    s_tdata,
    input  logic                        s_tvalid,
    output logic                        s_tready,
    input  logic                        s_tlast,
    input  stream_pack_pkg::lane_t      s_tdest,

    // wide output stream
    output logic [out_data_width-1:0]   m_tdata,
    output logic [out_data_width/8-1:0] m_tkeep,
    output logic                        m_tvalid,
    input  logic                        m_tready,
    output logic                        m_tlast,
    output stream_pack_pkg::lane_t      m_tdest
);

    localparam int in_keep_width  = in_data_width / 8;
    localparam int out_keep_width = out_data_width / 8;

    // dispatcher to adapters
    axis_if #(.data_width(in_data_width), .keep_width(in_keep_width)) narrow [chan_count] ();

    // adapters to merger
    axis_if #(.data_width(out_data_width), .keep_width(out_keep_width)) wide [chan_count] ();

    axis_dispatch #(
        .chan_count (chan_count),
        .data_width (in_data_width)
    ) u_dispatch (
        .clk      (clk),
        .rstn     (rstn),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tdest  (s_tdest),
        .lanes    (narrow)
    );

    for (genvar i = 0; i < chan_count; i++) begin : g_lane
        axis_adapter #(
            .s_data_width (in_data_width),
            .m_data_width (out_data_width)
        ) u_adapter (
            .clk  (clk),
            .rstn (rstn),
            .s    (narrow[i]),
            .m    (wide[i])
        );
    end

    axis_merge #(
        .chan_count (chan_count),
        .data_width (out_data_width),
        .keep_width (out_keep_width)
    ) u_merge (
        .clk      (clk),
        .rstn     (rstn),
        .lanes    (wide),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tdest  (m_tdest)
    );

endmodule

//--- stream_pack.f
src/stream_pack_pkg.sv
src/axis_if.sv
src/axis_dispatch.sv
src/axis_adapter.sv
src/axis_merge.sv
src/stream_pack_top.sv
test/stream_pack_assertions.sv
test/stream_pack_tb.sv

//--- test/stream_pack_assertions.sv
////////////////////
// stream packer output checks
// handshake and packet rules on the wide output port
////////////////////

module stream_pack_assertions (
    input logic                                       clk,
    input logic                                       rstn,
    input logic [stream_pack_pkg::out_data_width-1:0] m_tdata,
    input logic [stream_pack_pkg::out_keep_width-1:0] m_tkeep,
    input logic                                       m_tvalid,
    input logic                                       m_tready,
    input logic                                       m_tlast,
    input stream_pack_pkg::lane_t                     m_tdest
);

    int fail_count = 0;

    logic                   pkt_open;
    stream_pack_pkg::lane_t pkt_dest;

    // lane of the output packet in progress
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pkt_open <= 1'b0;
            pkt_dest <= '0;
        end else if (m_tvalid && m_tready) begin
            pkt_open <= !m_tlast;
            pkt_dest <= m_tdest;
        end
    end

    reset_clears_valid: assert property (@(posedge clk) !rstn |=> !m_tvalid)
        else begin
            fail_count++;
            $error("m_tvalid high right after reset");
        end

    // an offered beat is held until it transfers
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rstn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
                                  && $stable(m_tlast) && $stable(m_tdest))
        else begin
            fail_count++;
            $error("output beat changed while stalled");
        end

    keep_not_empty: assert property (@(posedge clk) disable iff (!rstn)
        m_tvalid |-> m_tkeep != '0)
        else begin
            fail_count++;
            $error("m_tkeep is zero on a valid beat");
        end

    dest_fixed_in_packet: assert property (@(posedge clk) disable iff (!rstn)
        m_tvalid && pkt_open |-> m_tdest == pkt_dest)
        else begin
            fail_count++;
            $error("m_tdest changed inside an output packet");
        end

endmodule

bind stream_pack_top stream_pack_assertions u_assert (
    .clk      (clk),
    .rstn     (rstn),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .m_tdest  (m_tdest)
);

//--- test/stream_pack_tb.sv
////////////////////
// stream packer testbench
// directed tests against a per-lane scoreboard of packed words
////////////////////

module stream_pack_tb;

    localparam int lane_count = stream_pack_pkg::chan_count;
    localparam int dw         = stream_pack_pkg::out_data_width;
    localparam int kw         = stream_pack_pkg::out_keep_width;
    localparam int max_cycles = 4000;

    logic                   clk;
    logic                   rstn;
    logic [7:0]             s_tdata;
    logic                   s_tvalid;
    logic                   s_tready;
    logic                   s_tlast;
    stream_pack_pkg::lane_t s_tdest;
    logic [dw-1:0]          m_tdata;
    logic [kw-1:0]          m_tkeep;
    logic                   m_tvalid;
    logic                   m_tready;
    logic                   m_tlast;
    stream_pack_pkg::lane_t m_tdest;

    // expected words per lane as {last, keep, data}
    logic [dw+kw:0]         exp_q [lane_count][$];
    int                     errors = 0;
    int                     words_seen = 0;
    int                     cycle_count = 0;
    int                     total_errors;
    // 0 holds m_tready low, 1 holds it high, 2 randomizes it
    int                     ready_mode = 1;
    logic [31:0]            rng_state;
    logic                   out_open = 1'b0;
    stream_pack_pkg::lane_t out_dest = '0;

    stream_pack_top #(
        .chan_count     (lane_count),
        .in_data_width  (stream_pack_pkg::in_data_width),
        .out_data_width (dw)
    ) UUT (
        .clk      (clk),
        .rstn     (rstn),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tdest  (s_tdest),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tdest  (m_tdest)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // m_tready follows the mode latched at the edge and changes just after it
    initial begin : ready_drive
        int mode;
        m_tready  = 1'b1;
        rng_state = 32'd82099;
        forever begin
            @(posedge clk);
            mode = ready_mode;
            #1;
            if (mode == 0) begin
                m_tready = 1'b0;
            end else if (mode == 2) begin
                rng_state = xorshift32(rng_state);
                m_tready  = rng_state[7];
            end else begin
                m_tready = 1'b1;
            end
        end
    end

    // values are settled here ahead of the transfer on the next rising edge
    always @(negedge clk) begin : monitor
        logic [dw+kw:0] exp_word;
        if (rstn && m_tvalid && m_tready) begin
            words_seen++;
            if (out_open) begin
                check_value("m_tdest", m_tdest, out_dest);
            end
            if (exp_q[m_tdest].size() == 0) begin
                errors++;
                $display("unexpected output word on lane %0d at time %0t", m_tdest, $time);
            end else begin
                exp_word = exp_q[m_tdest].pop_front();
                check_value("m_tdata", m_tdata, exp_word[dw-1:0]);
                check_value("m_tkeep", m_tkeep, exp_word[dw +: kw]);
                check_value("m_tlast", m_tlast, exp_word[dw+kw]);
            end
            out_open = !m_tlast;
            out_dest = m_tdest;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run still busy after %0d cycles, %0d errors so far",
                     max_cycles, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // sends one packet and queues its expected words packed little-endian
    task automatic send_packet(input int lane, input int len, input logic [7:0] seed);
        logic [7:0]    pkt [$];
        logic [dw-1:0] word;
        logic [kw-1:0] keep;
        logic          last_w;
        int            n;
        bit            accepted;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(seed + 8'(i * 7));
        end
        word = '0;
        keep = '0;
        n    = 0;
        for (int i = 0; i < len; i++) begin
            word[n*8 +: 8] = pkt[i];
            keep[n]        = 1'b1;
            n++;
            last_w = (i == len - 1);
            if (n == kw || last_w) begin
                exp_q[lane].push_back({last_w, keep, word});
                word = '0;
                keep = '0;
                n    = 0;
            end
        end
        for (int i = 0; i < len; i++) begin
            s_tvalid = 1'b1;
            s_tdata  = pkt[i];
            s_tlast  = (i == len - 1);
            s_tdest  = stream_pack_pkg::lane_t'(lane);
            do begin
                @(negedge clk);
                accepted = s_tready;
                @(posedge clk);
                #1;
            end while (!accepted);
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic wait_drain();
        int pending;
        do begin
            @(posedge clk);
            #1;
            pending = 0;
            for (int l = 0; l < lane_count; l++) begin
                pending += exp_q[l].size();
            end
        end while (pending != 0 || out_open);
    endtask

    task automatic reset_state();
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("m_tvalid", m_tvalid, 1'b0);
        check_value("s_tready", s_tready, 1'b1);
        repeat (7) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_value("m_tvalid", m_tvalid, 1'b0);
        check_value("s_tready", s_tready, 1'b1);
        @(posedge clk);
        #1;
    endtask

    task automatic full_words();
        send_packet(1, 8, 8'h10);
        wait_drain();
    endtask

    task automatic partial_last_word();
        send_packet(2, 1, 8'ha0);
        send_packet(2, 2, 8'hb0);
        send_packet(2, 3, 8'hc0);
        send_packet(2, 5, 8'hd0);
        wait_drain();
    endtask

    task automatic lane_routing();
        for (int l = 0; l < lane_count; l++) begin
            send_packet(l, 6, 8'h40 + 8'(l * 16));
        end
        wait_drain();
    endtask

    task automatic random_backpressure();
        int lens [8] = '{3, 9, 4, 7, 1, 12, 5, 8};
        ready_mode = 2;
        for (int p = 0; p < 8; p++) begin
            send_packet(p % lane_count, lens[p], 8'(p * 29));
        end
        wait_drain();
        ready_mode = 1;
    endtask

    // short packets park in lanes 1 to 3 while lane 0 stalls mid-packet
    task automatic stalled_lane_drain();
        ready_mode = 0;
        send_packet(1, 3, 8'h61);
        send_packet(2, 4, 8'h72);
        send_packet(3, 2, 8'h83);
        fork
            send_packet(0, 10, 8'h94);
            begin
                repeat (20) @(posedge clk);
                #1;
                ready_mode = 1;
            end
        join
        send_packet(1, 6, 8'ha5);
        wait_drain();
    endtask

    initial begin
        s_tdata  = '0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tdest  = '0;
        rstn     = 1'b0;
        reset_state();
        full_words();
        partial_last_word();
        lane_routing();
        random_backpressure();
        stalled_lane_drain();
        total_errors = errors + UUT.u_assert.fail_count;
        $display("errors: %0d check, %0d assertion, %0d output words seen",
                 errors, UUT.u_assert.fail_count, words_seen);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
